/* source/tk1_pkg.sv */
// Shared widths, register addresses, identity constants, SoC address map and CPU address union
`default_nettype none

package tk1_pkg;

  // ------------------------------------------------------------
  // Bus and register map
  // ------------------------------------------------------------
  localparam int DATA_W     = 32;
  localparam int BUS_ADDR_W = 8;

  localparam logic [BUS_ADDR_W-1:0] ADDR_NAME0         = 8'h00;
  localparam logic [BUS_ADDR_W-1:0] ADDR_NAME1         = 8'h01;
  localparam logic [BUS_ADDR_W-1:0] ADDR_VERSION       = 8'h02;
  localparam logic [BUS_ADDR_W-1:0] ADDR_LED           = 8'h09;
  localparam logic [BUS_ADDR_W-1:0] ADDR_GPIO          = 8'h0a;
  localparam logic [BUS_ADDR_W-1:0] ADDR_APP_START     = 8'h0c;
  localparam logic [BUS_ADDR_W-1:0] ADDR_APP_SIZE      = 8'h0d;
  localparam logic [BUS_ADDR_W-1:0] ADDR_CDI_FIRST     = 8'h20;
  localparam logic [BUS_ADDR_W-1:0] ADDR_CDI_LAST      = 8'h27;
  localparam logic [BUS_ADDR_W-1:0] ADDR_CPU_MON_CTRL  = 8'h60;
  localparam logic [BUS_ADDR_W-1:0] ADDR_CPU_MON_FIRST = 8'h61;
  localparam logic [BUS_ADDR_W-1:0] ADDR_CPU_MON_LAST  = 8'h62;

  // Identity words, ASCII "tk1 " and "mkdf"
  localparam logic [DATA_W-1:0] TK1_NAME0   = 32'h746b_3120;
  localparam logic [DATA_W-1:0] TK1_NAME1   = 32'h6d6b_6466;
  localparam logic [DATA_W-1:0] TK1_VERSION = 32'h0000_0005;

  localparam logic [DATA_W-1:0] APP_SIZE_RESET = 32'h0000_0000;
  localparam logic [2:0]        LED_RESET      = 3'b110;

  localparam int LED_R_BIT = 2;
  localparam int LED_G_BIT = 1;
  localparam int LED_B_BIT = 0;
  localparam int GPIO3_BIT = 2;
  localparam int GPIO4_BIT = 3;

  // ------------------------------------------------------------
  // SoC address map
  // ------------------------------------------------------------
  localparam logic [DATA_W-1:0] FW_ROM_LAST  = 32'h0000_1fff;
  localparam logic [DATA_W-1:0] FW_RAM_FIRST = 32'hd000_0000;
  localparam logic [DATA_W-1:0] FW_RAM_LAST  = 32'hd000_0fff;

  localparam logic [1:0] REGION_ROM  = 2'd0;
  localparam logic [1:0] REGION_RAM  = 2'd1;
  localparam logic [1:0] REGION_RSVD = 2'd2;
  localparam logic [1:0] REGION_MMIO = 2'd3;

  localparam int ROM_OFFSET_W = 13;
  localparam int RAM_OFFSET_W = 17;

  localparam logic [5:0] CORE_TRNG    = 6'h00;
  localparam logic [5:0] CORE_TIMER   = 6'h01;
  localparam logic [5:0] CORE_UDS     = 6'h02;
  localparam logic [5:0] CORE_UART    = 6'h03;
  localparam logic [5:0] CORE_TOUCH   = 6'h04;
  localparam logic [5:0] CORE_FW_RAM  = 6'h10;
  localparam logic [5:0] CORE_SYSCALL = 6'h21;
  localparam logic [5:0] CORE_TK1     = 6'h3f;

  // Offset widths inside an MMIO core
  localparam int MMIO_OFFSET_W    = 10;
  localparam int UDS_OFFSET_W     = 5;
  localparam int FW_RAM_OFFSET_W  = 12;
  localparam int SYSCALL_OFFSET_W = 2;

  localparam int TRAP_BLINK_W = 24;

  // Flat word for range compares, fields for map checks
  typedef union packed {
    logic [DATA_W-1:0] word;
    struct packed {
      logic [1:0]  region;
      logic [5:0]  core;
      logic [23:0] offset;
    } fields;
  } cpu_addr_t;

endpackage

`default_nettype wire

/* source/tk1_mode_fsm.sv */
// Firmware to application privilege state machine
`default_nettype none

module tk1_mode_fsm (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       cpu_valid,
  input  logic                       cpu_instr,
  input  logic [tk1_pkg::DATA_W-1:0] cpu_addr,
  input  logic                       syscall,
  output logic                       fw_startup_done,
  output logic                       app_mode
);
  import tk1_pkg::*;

  // Low in firmware, high in application
  logic state_q;
  logic state_d;

  // One way only, leave firmware on the first fetch above ROM
  always_comb begin
    state_d = state_q;
    if (!state_q && cpu_valid && cpu_instr && (cpu_addr > FW_ROM_LAST)) begin
      state_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_q <= 1'b0;
    end else begin
      state_q <= state_d;
    end
  end

  assign fw_startup_done = state_q;

  // A syscall runs with firmware privilege
  assign app_mode = state_q && !syscall;

endmodule

`default_nettype wire

/* source/tk1_trap_blinker.sv */
// Trap blink timer and LED output mux
`default_nettype none

module tk1_trap_blinker (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       cpu_trap,
  input  logic [2:0] led_value,
  output logic       led_r,
  output logic       led_g,
  output logic       led_b
);
  import tk1_pkg::*;

  logic [TRAP_BLINK_W-1:0] timer_q;
  logic [2:0]              blink_q;
  logic [2:0]              led_mux;

  // Free-running, red toggles on every wrap
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      timer_q <= '0;
      blink_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
      if (timer_q == '0) begin
        blink_q[LED_R_BIT] <= !blink_q[LED_R_BIT];
      end
    end
  end

  // Blink pattern replaces the LED register while trapped
  assign led_mux = cpu_trap ? blink_q : led_value;

  assign led_r = led_mux[LED_R_BIT];
  assign led_g = led_mux[LED_G_BIT];
  assign led_b = led_mux[LED_B_BIT];

endmodule

`default_nettype wire

/* source/tk1_sec_monitor.sv */
// CPU access checker against the SoC map and execution rules, sticky force_trap
`default_nettype none

module tk1_sec_monitor (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       cpu_valid,
  input  logic                       cpu_instr,
  input  tk1_pkg::cpu_addr_t         cpu_addr,
  input  logic                       app_mode,
  input  logic                       mon_en,
  input  logic [tk1_pkg::DATA_W-1:0] mon_first,
  input  logic [tk1_pkg::DATA_W-1:0] mon_last,
  output logic                       force_trap
);
  import tk1_pkg::*;

  logic [DATA_W-3:0] region_offset;
  logic              core_used;
  logic [4:0]        core_off_w;
  logic              map_hit;
  logic              instr_hit;
  logic              force_trap_q;

  // Everything below the region bits
  assign region_offset = {cpu_addr.fields.core, cpu_addr.fields.offset};

  // ------------------------------------------------------------
  // MMIO core decode
  // ------------------------------------------------------------
  always_comb begin
    core_used  = 1'b1;
    core_off_w = 5'(MMIO_OFFSET_W);
    case (cpu_addr.fields.core)
      CORE_TRNG, CORE_TIMER, CORE_UART, CORE_TOUCH, CORE_TK1: begin
        core_off_w = 5'(MMIO_OFFSET_W);
      end
      CORE_UDS:     core_off_w = 5'(UDS_OFFSET_W);
      CORE_FW_RAM:  core_off_w = 5'(FW_RAM_OFFSET_W);
      CORE_SYSCALL: core_off_w = 5'(SYSCALL_OFFSET_W);
      default:      core_used  = 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // Address map rules
  // ------------------------------------------------------------
  always_comb begin
    map_hit = 1'b0;
    case (cpu_addr.fields.region)
      REGION_ROM:  map_hit = (region_offset >> ROM_OFFSET_W) != '0;
      REGION_RAM:  map_hit = (region_offset >> RAM_OFFSET_W) != '0;
      REGION_RSVD: map_hit = 1'b1;
      REGION_MMIO: begin
        map_hit = !core_used || ((cpu_addr.fields.offset >> core_off_w) != '0);
      end
    endcase
  end

  // ------------------------------------------------------------
  // Execution rules
  // ------------------------------------------------------------
  always_comb begin
    instr_hit = 1'b0;
    if (cpu_instr) begin
      // No code runs from firmware RAM
      if ((cpu_addr.word >= FW_RAM_FIRST) && (cpu_addr.word <= FW_RAM_LAST)) begin
        instr_hit = 1'b1;
      end
      // ROM starts at zero, so one compare covers it
      if (app_mode && (cpu_addr.word <= FW_ROM_LAST)) begin
        instr_hit = 1'b1;
      end
      // Data-only window set up by firmware
      if (mon_en && (cpu_addr.word >= mon_first) && (cpu_addr.word <= mon_last)) begin
        instr_hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap_q <= 1'b0;
    end else if (cpu_valid && (map_hit || instr_hit)) begin
      force_trap_q <= 1'b1;
    end
  end

  assign force_trap = force_trap_q;

endmodule

`default_nettype wire

/* source/tk1_regs.sv */
// Register bus decode, register storage, GPIO synchronisers and read mux
`default_nettype none

module tk1_regs (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cs,
  input  logic                           we,
  input  logic [tk1_pkg::BUS_ADDR_W-1:0] address,
  input  logic [tk1_pkg::DATA_W-1:0]     write_data,
  output logic [tk1_pkg::DATA_W-1:0]     read_data,
  output logic                           ready,
  input  logic                           app_mode,
  input  logic                           gpio1,
  input  logic                           gpio2,
  output logic                           gpio3,
  output logic                           gpio4,
  output logic [2:0]                     led_value,
  output logic                           mon_en,
  output logic [tk1_pkg::DATA_W-1:0]     mon_first,
  output logic [tk1_pkg::DATA_W-1:0]     mon_last
);
  import tk1_pkg::*;

  logic              bus_write;
  logic [2:0]        cdi_idx;
  logic [2:0]        led_q;
  logic              gpio3_q;
  logic              gpio4_q;
  logic [1:0]        gpio1_sync;
  logic [1:0]        gpio2_sync;
  logic [DATA_W-1:0] app_start_q;
  logic [DATA_W-1:0] app_size_q;
  logic [DATA_W-1:0] cdi_mem [0:7];
  logic              mon_en_q;
  logic [DATA_W-1:0] mon_first_q;
  logic [DATA_W-1:0] mon_last_q;

  assign bus_write = cs && we;
  assign cdi_idx   = address[2:0];

  // ------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_q       <= LED_RESET;
      gpio3_q     <= 1'b0;
      gpio4_q     <= 1'b0;
      gpio1_sync  <= '0;
      gpio2_sync  <= '0;
      app_start_q <= '0;
      app_size_q  <= APP_SIZE_RESET;
      for (int i = 0; i < 8; i++) begin
        cdi_mem[i] <= '0;
      end
      mon_en_q    <= 1'b0;
      mon_first_q <= '0;
      mon_last_q  <= '0;
    end else begin
      // Two-stage input synchronisers
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};

      if (bus_write) begin
        case (address) inside
          ADDR_LED: led_q <= write_data[2:0];
          ADDR_GPIO: begin
            gpio3_q <= write_data[GPIO3_BIT];
            gpio4_q <= write_data[GPIO4_BIT];
          end
          // Firmware-only registers
          ADDR_APP_START: if (!app_mode) app_start_q <= write_data;
          ADDR_APP_SIZE:  if (!app_mode) app_size_q <= write_data;
          [ADDR_CDI_FIRST:ADDR_CDI_LAST]: if (!app_mode) cdi_mem[cdi_idx] <= write_data;
          // Enable locks the window until reset
          ADDR_CPU_MON_CTRL:  mon_en_q <= 1'b1;
          ADDR_CPU_MON_FIRST: if (!mon_en_q) mon_first_q <= write_data;
          ADDR_CPU_MON_LAST:  if (!mon_en_q) mon_last_q <= write_data;
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (cs && !we) begin
      case (address) inside
        ADDR_NAME0:     read_data = TK1_NAME0;
        ADDR_NAME1:     read_data = TK1_NAME1;
        ADDR_VERSION:   read_data = TK1_VERSION;
        ADDR_LED:       read_data = {{(DATA_W-3){1'b0}}, led_q};
        ADDR_GPIO: begin
          read_data = {{(DATA_W-4){1'b0}}, gpio4_q, gpio3_q, gpio2_sync[1], gpio1_sync[1]};
        end
        ADDR_APP_START: read_data = app_start_q;
        ADDR_APP_SIZE:  read_data = app_size_q;
        [ADDR_CDI_FIRST:ADDR_CDI_LAST]: read_data = cdi_mem[cdi_idx];
        default:        read_data = '0;
      endcase
    end
  end

  // Every access completes in its own cycle
  assign ready = cs;

  assign gpio3     = gpio3_q;
  assign gpio4     = gpio4_q;
  assign led_value = led_q;
  assign mon_en    = mon_en_q;
  assign mon_first = mon_first_q;
  assign mon_last  = mon_last_q;

endmodule

`default_nettype wire

/* source/tk1_top.sv */
// Top level of the control and security core
`default_nettype none

module tk1_top (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           cs,
  input  logic                           we,
  input  logic [tk1_pkg::BUS_ADDR_W-1:0] address,
  input  logic [tk1_pkg::DATA_W-1:0]     write_data,
  output logic [tk1_pkg::DATA_W-1:0]     read_data,
  output logic                           ready,
  input  logic                           cpu_valid,
  input  logic                           cpu_instr,
  input  logic [tk1_pkg::DATA_W-1:0]     cpu_addr,
  input  logic                           cpu_trap,
  input  logic                           syscall,
  input  logic                           gpio1,
  input  logic                           gpio2,
  output logic                           app_mode,
  output logic                           fw_startup_done,
  output logic                           force_trap,
  output logic                           led_r,
  output logic                           led_g,
  output logic                           led_b,
  output logic                           gpio3,
  output logic                           gpio4
);
  import tk1_pkg::*;

  logic [2:0]        led_value;
  logic              mon_en;
  logic [DATA_W-1:0] mon_first;
  logic [DATA_W-1:0] mon_last;

  tk1_mode_fsm mode_fsm_i (
    .clk(clk), .reset_n(reset_n), .cpu_valid(cpu_valid), .cpu_instr(cpu_instr),
    .cpu_addr(cpu_addr), .syscall(syscall), .fw_startup_done(fw_startup_done),
    .app_mode(app_mode)
  );

  tk1_trap_blinker blinker_i (
    .clk(clk), .reset_n(reset_n), .cpu_trap(cpu_trap), .led_value(led_value),
    .led_r(led_r), .led_g(led_g), .led_b(led_b)
  );

  tk1_sec_monitor sec_monitor_i (
    .clk(clk), .reset_n(reset_n), .cpu_valid(cpu_valid), .cpu_instr(cpu_instr),
    .cpu_addr(cpu_addr), .app_mode(app_mode), .mon_en(mon_en),
    .mon_first(mon_first), .mon_last(mon_last), .force_trap(force_trap)
  );

  tk1_regs regs_i (
    .clk(clk), .reset_n(reset_n), .cs(cs), .we(we), .address(address),
    .write_data(write_data), .read_data(read_data), .ready(ready),
    .app_mode(app_mode), .gpio1(gpio1), .gpio2(gpio2), .gpio3(gpio3), .gpio4(gpio4),
    .led_value(led_value), .mon_en(mon_en), .mon_first(mon_first), .mon_last(mon_last)
  );

endmodule

`default_nettype wire

/* test/tk1_chk.sv */
// Concurrent assertions on the bus handshake and the sticky status outputs
`default_nettype none

module tk1_chk (
  input logic clk,
  input logic reset_n,
  input logic cs,
  input logic ready,
  input logic force_trap,
  input logic fw_startup_done,
  input logic app_mode
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench at the end of the run
  int failures = 0;

  ready_follows_cs: assert property (@(posedge clk) ready == cs)
    else begin
      failures++;
      $error("ready differs from cs");
    end

  // Only a reset may clear these two
  trap_is_sticky: assert property (@(posedge clk) reset_n && force_trap |=> force_trap)
    else begin
      failures++;
      $error("force_trap fell without a reset");
    end

  startup_is_sticky: assert property (
    @(posedge clk) reset_n && fw_startup_done |=> fw_startup_done)
    else begin
      failures++;
      $error("fw_startup_done fell without a reset");
    end

  app_needs_startup: assert property (
    @(posedge clk) disable iff (!reset_n) app_mode |-> fw_startup_done)
    else begin
      failures++;
      $error("app_mode is high before fw_startup_done");
    end

endmodule

bind tk1_top tk1_chk chk_i (
  .clk(clk),
  .reset_n(reset_n),
  .cs(cs),
  .ready(ready),
  .force_trap(force_trap),
  .fw_startup_done(fw_startup_done),
  .app_mode(app_mode)
);

`default_nettype wire

/* test/tb_tk1.sv */
// Testbench for the control and security core with clock, reset, stimulus, model and watchdog
`default_nettype none

module tb_tk1;
  timeunit 1ns;
  timeprecision 1ps;
  import tk1_pkg::*;

  localparam int PERIOD = 8;
  localparam int N_BUS  = 300;
  localparam int N_CPU  = 200;
  // Bus steps take up to 2 cycles, CPU steps up to 4
  localparam int TIMEOUT_NS = ((N_BUS * 2) + (N_CPU * 4) + 500) * PERIOD;

  logic        clk;
  logic        reset_n;
  logic        cs;
  logic        we;
  logic [7:0]  address;
  logic [31:0] write_data;
  logic [31:0] read_data;
  logic        ready;
  logic        cpu_valid;
  logic        cpu_instr;
  logic [31:0] cpu_addr;
  logic        cpu_trap;
  logic        syscall;
  logic        gpio1;
  logic        gpio2;
  logic        app_mode;
  logic        fw_startup_done;
  logic        force_trap;
  logic        led_r;
  logic        led_g;
  logic        led_b;
  logic        gpio3;
  logic        gpio4;

  // Reference model state
  logic [2:0]  m_led;
  logic        m_gpio3;
  logic        m_gpio4;
  logic [1:0]  m_gpio_in;
  logic [31:0] m_app_start;
  logic [31:0] m_app_size;
  logic [31:0] m_cdi [0:7];
  logic        m_mon_en;
  logic [31:0] m_mon_first;
  logic [31:0] m_mon_last;
  logic        m_fw_done;
  logic        m_trap;
  int unsigned edges;
  logic [31:0] rng = 32'd92;
  int          checks = 0;
  int          errors = 0;

  tk1_top dut_i (
    .clk(clk), .reset_n(reset_n), .cs(cs), .we(we), .address(address),
    .write_data(write_data), .read_data(read_data), .ready(ready),
    .cpu_valid(cpu_valid), .cpu_instr(cpu_instr), .cpu_addr(cpu_addr),
    .cpu_trap(cpu_trap), .syscall(syscall), .gpio1(gpio1), .gpio2(gpio2),
    .app_mode(app_mode), .fw_startup_done(fw_startup_done), .force_trap(force_trap),
    .led_r(led_r), .led_g(led_g), .led_b(led_b), .gpio3(gpio3), .gpio4(gpio4)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Rising edges since reset, the blinker's timer follows this count
  always @(posedge clk) begin
    if (!reset_n) begin
      edges <= 0;
    end else begin
      edges <= edges + 1;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Random numbers and model functions
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] addr);
    case (addr) inside
      8'h00: return "tk1 ";
      8'h01: return "mkdf";
      8'h02: return 32'd5;
      8'h09: return {29'b0, m_led};
      8'h0a: return {28'b0, m_gpio4, m_gpio3, m_gpio_in};
      8'h0c: return m_app_start;
      8'h0d: return m_app_size;
      [8'h20:8'h27]: return m_cdi[addr[2:0]];
      default: return 32'd0;
    endcase
  endfunction

  // Map rules on the fields, execution rules on the flat word
  function automatic logic model_fault(input cpu_addr_t a, input logic instr,
                                       input logic app);
    logic map_bad;
    logic exe_bad;
    int   width;
    width = 0;
    case (a.fields.region)
      2'd0: map_bad = (a.word[29:0] >> 13) != '0;
      2'd1: map_bad = (a.word[29:0] >> 17) != '0;
      2'd2: map_bad = 1'b1;
      default: begin
        case (a.fields.core)
          6'h00, 6'h01, 6'h03, 6'h04, 6'h3f: width = 10;
          6'h02: width = 5;
          6'h10: width = 12;
          6'h21: width = 2;
          default: width = 0;
        endcase
        map_bad = (width == 0) || ((a.fields.offset >> width) != '0);
      end
    endcase
    exe_bad = instr && (((a.word >= 32'hd000_0000) && (a.word <= 32'hd000_0fff)) ||
                        (app && (a.word <= 32'h0000_1fff)) ||
                        (m_mon_en && (a.word >= m_mon_first) && (a.word <= m_mon_last)));
    return map_bad || exe_bad;
  endfunction

  // Red toggles on the first edge after reset and every 2^24 edges after
  function automatic logic model_blink_red(input int unsigned n);
    return (n != 0) && ((((n - 1) >> 24) % 2) == 0);
  endfunction

  function automatic logic [5:0] used_core(input logic [2:0] k);
    case (k)
      3'd0: return 6'h00;
      3'd1: return 6'h01;
      3'd2: return 6'h02;
      3'd3: return 6'h03;
      3'd4: return 6'h04;
      3'd5: return 6'h10;
      3'd6: return 6'h21;
      default: return 6'h3f;
    endcase
  endfunction

  function automatic logic [7:0] pick_addr(input logic [31:0] r);
    case (r[5:3])
      3'd0: return ADDR_LED;
      3'd1: return ADDR_GPIO;
      3'd2: return ADDR_APP_START;
      3'd3: return ADDR_APP_SIZE;
      default: return {5'b00100, r[12:10]};
    endcase
  endfunction

  // ------------------------------------------------------------
  // Checks and bus tasks
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    logic [2:0] exp_led;
    exp_led = cpu_trap ? {model_blink_red(edges), 2'b00} : m_led;
    check_value("force_trap", 32'(force_trap), 32'(m_trap));
    check_value("fw_startup_done", 32'(fw_startup_done), 32'(m_fw_done));
    check_value("app_mode", 32'(app_mode), 32'(m_fw_done && !syscall));
    check_value("gpio3", 32'(gpio3), 32'(m_gpio3));
    check_value("gpio4", 32'(gpio4), 32'(m_gpio4));
    check_value("led_rgb", 32'({led_r, led_g, led_b}), 32'(exp_led));
  endtask

  task automatic apply_reset(input int cycles);
    reset_n = 1'b0;
    cs = 1'b0;
    we = 1'b0;
    address = '0;
    write_data = '0;
    cpu_valid = 1'b0;
    cpu_instr = 1'b0;
    cpu_addr = '0;
    cpu_trap = 1'b0;
    syscall = 1'b0;
    gpio1 = 1'b0;
    gpio2 = 1'b0;
    repeat (cycles) @(negedge clk);
    reset_n = 1'b1;
    m_led = 3'b110;
    m_gpio3 = 1'b0;
    m_gpio4 = 1'b0;
    m_gpio_in = 2'b00;
    m_app_start = '0;
    m_app_size = '0;
    for (int i = 0; i < 8; i++) begin
      m_cdi[i] = '0;
    end
    m_mon_en = 1'b0;
    m_mon_first = '0;
    m_mon_last = '0;
    m_fw_done = 1'b0;
    m_trap = 1'b0;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    logic app;
    app = m_fw_done && !syscall;
    cs = 1'b1;
    we = 1'b1;
    address = addr;
    write_data = data;
    #2;
    check_value("ready", 32'(ready), 32'd1);
    check_value("read_data", read_data, 32'd0);
    case (addr) inside
      8'h09: m_led = data[2:0];
      8'h0a: begin
        m_gpio3 = data[2];
        m_gpio4 = data[3];
      end
      8'h0c: if (!app) m_app_start = data;
      8'h0d: if (!app) m_app_size = data;
      [8'h20:8'h27]: if (!app) m_cdi[addr[2:0]] = data;
      8'h60: m_mon_en = 1'b1;
      8'h61: if (!m_mon_en) m_mon_first = data;
      8'h62: if (!m_mon_en) m_mon_last = data;
      default: ;
    endcase
    @(negedge clk);
    check_outputs();
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr);
    cs = 1'b1;
    we = 1'b0;
    address = addr;
    write_data = xorshift32();
    #2;
    check_value("ready", 32'(ready), 32'd1);
    check_value("read_data", read_data, model_read(addr));
    @(negedge clk);
    check_outputs();
    cs = 1'b0;
  endtask

  // Levels are held long enough to pass the synchronisers
  task automatic set_gpio_inputs(input logic g1, input logic g2);
    gpio1 = g1;
    gpio2 = g2;
    m_gpio_in = {g2, g1};
    repeat (2) @(negedge clk);
    check_outputs();
  endtask

  task automatic cpu_access(input logic [31:0] addr, input logic instr);
    cpu_valid = 1'b1;
    cpu_instr = instr;
    cpu_addr = addr;
    if (model_fault(addr, instr, m_fw_done && !syscall)) m_trap = 1'b1;
    if (instr && (addr > 32'h0000_1fff)) m_fw_done = 1'b1;
    @(negedge clk);
    check_outputs();
    cpu_valid = 1'b0;
    cpu_instr = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Test sections
  // ------------------------------------------------------------
  task automatic random_bus_step();
    logic [31:0] sel;
    sel = xorshift32();
    cpu_trap = sel[31];
    case (sel[2:0])
      3'd0, 3'd1: bus_write(pick_addr(sel), xorshift32());
      3'd2, 3'd3, 3'd4: bus_read(pick_addr(sel));
      3'd5: set_gpio_inputs(sel[8], sel[9]);
      default: bus_read(sel[23:16]);
    endcase
  endtask

  task automatic random_cpu_step();
    logic [31:0] r;
    cpu_addr_t   a;
    r = xorshift32();
    apply_reset(2);
    // Half of the accesses run in application mode
    if (r[0]) cpu_access(32'h4000_0100, 1'b1);
    syscall = r[1];
    a.word = xorshift32();
    case (r[4:2])
      3'd0: a.word = 32'hd000_0000 | {20'b0, a.word[11:0]};
      3'd1: a.word = {19'b0, a.word[12:0]};
      3'd2, 3'd3: a.word[29:0] = a.word[29:0] >> r[14:10];
      3'd4, 3'd5: begin
        a.fields.region = 2'd3;
        a.fields.core = used_core(r[17:15]);
        a.fields.offset = a.fields.offset >> r[22:18];
      end
      default: ;
    endcase
    cpu_access(a.word, r[5]);
    syscall = 1'b0;
  endtask

  task automatic window_test();
    logic [31:0] base;
    logic [31:0] span;
    base = 32'h4000_0000 | (xorshift32() & 32'h0000_7000);
    span = xorshift32() & 32'h0000_00ff;
    apply_reset(2);
    bus_write(ADDR_CPU_MON_FIRST, base);
    bus_write(ADDR_CPU_MON_LAST, base + span);
    bus_write(ADDR_CPU_MON_CTRL, xorshift32());
    // Bounds are locked once enabled
    bus_write(ADDR_CPU_MON_FIRST, 32'h4001_0000);
    bus_write(ADDR_CPU_MON_LAST, 32'h4001_0fff);
    cpu_access(32'h4001_0010, 1'b1);
    cpu_access(base + span + 32'd1, 1'b1);
    cpu_access(base + span, 1'b1);
  endtask

  task automatic blink_test();
    apply_reset(3);
    cpu_trap = 1'b1;
    #2;
    check_outputs();
    repeat (6) begin
      @(negedge clk);
      check_outputs();
    end
    bus_write(ADDR_LED, xorshift32());
    cpu_trap = 1'b0;
    bus_write(ADDR_LED, xorshift32());
  endtask

  initial begin
    int          assert_fails;
    logic [31:0] r;
    apply_reset(8);
    check_outputs();
    bus_read(ADDR_NAME0);
    bus_read(ADDR_NAME1);
    bus_read(ADDR_VERSION);
    repeat (20) bus_read(8'h80 | 8'(xorshift32()));
    repeat (N_BUS) random_bus_step();
    cpu_trap = 1'b0;
    // Leave firmware, then the firmware-only registers lock
    r = xorshift32();
    syscall = r[0];
    cpu_access(32'h4000_0000 | (xorshift32() & 32'h0001_fffc), 1'b1);
    syscall = 1'b0;
    r = xorshift32();
    bus_write(ADDR_APP_START, xorshift32());
    bus_write(ADDR_APP_SIZE, xorshift32());
    bus_write(ADDR_CDI_FIRST + 8'(r[2:0]), xorshift32());
    bus_write(ADDR_LED, xorshift32());
    bus_read(ADDR_APP_START);
    bus_read(ADDR_APP_SIZE);
    bus_read(ADDR_CDI_FIRST + 8'(r[2:0]));
    bus_read(ADDR_LED);
    repeat (N_CPU) random_cpu_step();
    window_test();
    blink_test();
    assert_fails = dut_i.chk_i.failures;
    errors += assert_fails;
    $display("Checks %0d, errors %0d, of them assertion failures %0d",
             checks, errors, assert_fails);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
source/tk1_pkg.sv
source/tk1_mode_fsm.sv
source/tk1_trap_blinker.sv
source/tk1_sec_monitor.sv
source/tk1_regs.sv
source/tk1_top.sv
test/tk1_chk.sv
test/tb_tk1.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_tk1
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)
